// ==== verilog.f ====
rtl/soc_bus_pkg.sv
rtl/bus_port_if.sv
rtl/bus_arbiter.sv
rtl/scratch_sram.sv
rtl/uart_tx_port.sv
rtl/clint_timer.sv
rtl/soc_bus_top.sv
verif/soc_bus_chk.sv
verif/soc_bus_tb.sv

// ==== verif/soc_bus_stimulus.txt ====
# columns, all hex: port op addr data strb expect; port 0 is ifu, 1 is lsu
# op 0 read, 1 write, 2 mtime rise, 3 idle data cycles, 4 lsu write racing ifu read, 5 ready mode (0 pattern 1 low 2 high), 6 write stalled by full fifo
1 1 80000000 deadbeef f 0
1 0 80000000 0 0 deadbeef
1 1 80000000 000000aa 1 0
1 1 80000000 00110000 4 0
1 0 80000000 0 0 de11beaa
1 1 80000004 00500093 f 0
0 0 80000004 0 0 00500093
1 1 80000008 ffffffff f 0
1 4 80000008 cafef00d 3 fffff00d
1 0 80000008 0 0 fffff00d
1 0 a000004c 0 0 0
1 2 a0000048 0 0 0
1 3 0 10 0 0
1 2 a0000048 0 0 0
1 5 0 0 0 0
1 1 a00003f8 48 1 0
1 1 a00003f8 69 1 0
1 1 a00003f8 21 1 0
1 1 a00003f8 0a 1 0
1 5 0 2 0 0
1 3 0 8 0 0
1 5 0 1 0 0
1 1 a00003f8 31 1 0
1 1 a00003f8 32 1 0
1 1 a00003f8 33 1 0
1 1 a00003f8 34 1 0
1 6 a00003f8 35 1 0
1 5 0 2 0 0
1 3 0 10 0 0
1 1 80000010 12345678 f 0
1 0 00000010 0 0 0
1 1 00000010 ffffffff f 0
1 0 80000010 0 0 12345678
0 0 90000000 0 0 0

// ==== verif/soc_bus_tb.sv ====
`timescale 1ns/1ns

module soc_bus_tb;

  localparam int CLK_HALF = 10;
  localparam int RESET_CYCLES = 8;
  localparam int CYCLES_PER_LINE = 200;
  localparam int STALL_CHECK_CYCLES = 8;
  // stimulus op codes
  localparam int OP_READ = 0;
  localparam int OP_WRITE = 1;
  localparam int OP_MTIME_RISE = 2;
  localparam int OP_IDLE = 3;
  localparam int OP_RACE = 4;
  localparam int OP_READY_MODE = 5;
  localparam int OP_STALL_WRITE = 6;
  // uart ready source
  localparam int READY_PATTERN = 0;

  logic        clk = 1'b0;
  logic        rst;
  logic        ifu_req_i;
  logic [31:0] ifu_addr_i;
  logic [31:0] ifu_rdata_o;
  logic        ifu_done_o;
  logic        lsu_req_i;
  logic        lsu_we_i;
  logic [31:0] lsu_addr_i;
  logic [31:0] lsu_wdata_i;
  logic [3:0]  lsu_wstrb_i;
  logic [31:0] lsu_rdata_o;
  logic        lsu_done_o;
  logic        uart_tx_ready_i;
  logic [7:0]  uart_tx_data_o;
  logic        uart_tx_valid_o;

  int          cycle = 0;
  int          err_total = 0;
  int          ifu_done_cnt = 0;
  int          lsu_done_cnt = 0;
  int          ready_mode = READY_PATTERN;
  int          n_lines = 0;
  bit          loaded = 1'b0;
  logic [31:0] rng = 32'd48248;
  logic [31:0] shadow [int];
  logic [7:0]  uart_expect [$];
  logic [31:0] st_port [$];
  logic [31:0] st_op [$];
  logic [31:0] st_addr [$];
  logic [31:0] st_data [$];
  logic [31:0] st_strb [$];
  logic [31:0] st_exp [$];

  soc_bus_top DUT (
    .clk             (clk),
    .rst             (rst),
    .ifu_req_i       (ifu_req_i),
    .ifu_addr_i      (ifu_addr_i),
    .ifu_rdata_o     (ifu_rdata_o),
    .ifu_done_o      (ifu_done_o),
    .lsu_req_i       (lsu_req_i),
    .lsu_we_i        (lsu_we_i),
    .lsu_addr_i      (lsu_addr_i),
    .lsu_wdata_i     (lsu_wdata_i),
    .lsu_wstrb_i     (lsu_wstrb_i),
    .lsu_rdata_o     (lsu_rdata_o),
    .lsu_done_o      (lsu_done_o),
    .uart_tx_ready_i (uart_tx_ready_i),
    .uart_tx_data_o  (uart_tx_data_o),
    .uart_tx_valid_o (uart_tx_valid_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic bit in_sram(input logic [31:0] addr);
    return addr >= soc_bus_pkg::SRAM_BASE &&
           (addr - soc_bus_pkg::SRAM_BASE) < soc_bus_pkg::SRAM_WORDS * 4;
  endfunction

  always #CLK_HALF clk = ~clk;

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    rng <= xorshift32(rng);
    case (ready_mode)
      READY_PATTERN: uart_tx_ready_i <= rng[0];
      1:             uart_tx_ready_i <= 1'b0;
      default:       uart_tx_ready_i <= 1'b1;
    endcase
  end

  // done counts and the uart byte stream, sampled mid-cycle
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (ifu_done_o)
        ifu_done_cnt++;
      if (lsu_done_o)
        lsu_done_cnt++;
      if (uart_tx_valid_o && uart_tx_ready_i)
      begin
        if (uart_expect.size() == 0)
        begin
          $display("uart byte 0x%02h sent with no write outstanding", uart_tx_data_o);
          err_total++;
        end
        else
        begin
          if (uart_tx_data_o !== uart_expect[0])
          begin
            $display("mismatch uart_tx_data_o: got 0x%02h expected 0x%02h",
                     uart_tx_data_o, uart_expect[0]);
            err_total++;
          end
          void'(uart_expect.pop_front());
        end
      end
    end
  end

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_port;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_strb;
    logic [31:0] f_exp;
    fd = $fopen("verif/soc_bus_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open verif/soc_bus_stimulus.txt");
      err_total++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        n = $fgets(line, fd);
        // comment lines fail to parse and drop out here
        if (n > 0 && $sscanf(line, "%h %h %h %h %h %h",
                             f_port, f_op, f_addr, f_data, f_strb, f_exp) == 6)
        begin
          st_port.push_back(f_port);
          st_op.push_back(f_op);
          st_addr.push_back(f_addr);
          st_data.push_back(f_data);
          st_strb.push_back(f_strb);
          st_exp.push_back(f_exp);
        end
      end
      $fclose(fd);
    end
    n_lines = st_op.size();
    if (n_lines == 0)
    begin
      $display("no stimulus lines were read");
      err_total++;
    end
    loaded = 1'b1;
  endtask

  // byte-strobe merge into the reference copy of the sram
  task automatic record_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb);
    int idx;
    if (in_sram(addr))
    begin
      idx = (addr - soc_bus_pkg::SRAM_BASE) >> 2;
      if (!shadow.exists(idx))
        shadow[idx] = 'x;
      for (int b = 0; b < 4; b++)
      begin
        if (strb[b])
          shadow[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  task automatic check_word(input int t, input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("mismatch test %0d %s: got 0x%08h expected 0x%08h", t, name, got, exp);
      err_total++;
    end
  endtask

  task automatic lsu_access(
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  strb,
    input  int          stall_cycles,
    output logic [31:0] rdata,
    output int          done_at
  );
    logic early;
    @(posedge clk);
    lsu_req_i   <= 1'b1;
    lsu_we_i    <= we;
    lsu_addr_i  <= addr;
    lsu_wdata_i <= wdata;
    lsu_wstrb_i <= strb;
    early = 1'b0;
    // full fifo must hold back done
    for (int i = 0; i < stall_cycles && !early; i++)
    begin
      @(negedge clk);
      early = lsu_done_o;
    end
    if (early)
    begin
      $display("lsu write to 0x%08h completed while the uart fifo was full", addr);
      err_total++;
    end
    else
    begin
      if (stall_cycles > 0)
        ready_mode = READY_PATTERN;
      do
        @(negedge clk);
      while (!lsu_done_o);
    end
    rdata = lsu_rdata_o;
    done_at = cycle;
    @(posedge clk);
    lsu_req_i <= 1'b0;
    lsu_we_i  <= 1'b0;
  endtask

  task automatic ifu_access(input logic [31:0] addr, output logic [31:0] rdata,
                            output int done_at);
    @(posedge clk);
    ifu_req_i  <= 1'b1;
    ifu_addr_i <= addr;
    do
      @(negedge clk);
    while (!ifu_done_o);
    rdata = ifu_rdata_o;
    done_at = cycle;
    @(posedge clk);
    ifu_req_i <= 1'b0;
  endtask

  initial
  begin
    wait (loaded);
    repeat (CYCLES_PER_LINE * (n_lines + 1)) @(posedge clk);
    $display("timeout at cycle %0d, a request never completed", cycle);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    logic [31:0] rdata;
    logic [31:0] ifu_rdata;
    logic [31:0] last_mtime;
    int          lsu_at;
    int          ifu_at;
    int          stall;
    int          err_before;
    int          ifu_before;
    int          lsu_before;
    int          n_pass;
    int          n_fail;
    rst = 1'b1;
    ifu_req_i = 1'b0;
    ifu_addr_i = '0;
    lsu_req_i = 1'b0;
    lsu_we_i = 1'b0;
    lsu_addr_i = '0;
    lsu_wdata_i = '0;
    lsu_wstrb_i = '0;
    uart_tx_ready_i = 1'b0;
    last_mtime = '0;
    n_pass = 0;
    n_fail = 0;
    load_stimulus();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int t = 0; t < n_lines; t++)
    begin
      err_before = err_total;
      case (st_op[t])
        OP_READ:
        begin
          if (st_port[t] == 0)
          begin
            ifu_access(st_addr[t], rdata, ifu_at);
            check_word(t, "ifu_rdata_o", rdata, st_exp[t]);
          end
          else
          begin
            lsu_access(1'b0, st_addr[t], '0, '0, 0, rdata, lsu_at);
            check_word(t, "lsu_rdata_o", rdata, st_exp[t]);
          end
          if (in_sram(st_addr[t]))
            check_word(t, "sram merge model", shadow[(st_addr[t] - soc_bus_pkg::SRAM_BASE) >> 2],
                       st_exp[t]);
        end
        OP_WRITE, OP_STALL_WRITE:
        begin
          stall = (st_op[t] == OP_STALL_WRITE) ? STALL_CHECK_CYCLES : 0;
          if (st_addr[t] == soc_bus_pkg::UART_TX_ADDR)
            uart_expect.push_back(st_data[t][7:0]);
          record_write(st_addr[t], st_data[t], st_strb[t][3:0]);
          lsu_access(1'b1, st_addr[t], st_data[t], st_strb[t][3:0], stall, rdata, lsu_at);
        end
        OP_MTIME_RISE:
        begin
          lsu_access(1'b0, st_addr[t], '0, '0, 0, rdata, lsu_at);
          if (rdata <= last_mtime)
          begin
            $display("mtime did not rise: read 0x%08h after 0x%08h", rdata, last_mtime);
            err_total++;
          end
          last_mtime = rdata;
        end
        OP_IDLE:
          repeat (st_data[t]) @(posedge clk);
        OP_READY_MODE:
        begin
          @(negedge clk);
          ready_mode = st_data[t];
        end
        OP_RACE:
        begin
          ifu_before = ifu_done_cnt;
          lsu_before = lsu_done_cnt;
          record_write(st_addr[t], st_data[t], st_strb[t][3:0]);
          fork
            lsu_access(1'b1, st_addr[t], st_data[t], st_strb[t][3:0], 0, rdata, lsu_at);
            ifu_access(st_addr[t], ifu_rdata, ifu_at);
          join
          repeat (2) @(posedge clk);
          if (ifu_done_cnt - ifu_before != 1 || lsu_done_cnt - lsu_before != 1)
          begin
            $display("expected one done per port, saw ifu %0d and lsu %0d",
                     ifu_done_cnt - ifu_before, lsu_done_cnt - lsu_before);
            err_total++;
          end
          if (lsu_at >= ifu_at)
          begin
            $display("lsu finished at cycle %0d, not before ifu at %0d", lsu_at, ifu_at);
            err_total++;
          end
          check_word(t, "ifu_rdata_o", ifu_rdata, st_exp[t]);
        end
        default:
        begin
          $display("unknown op %0d in stimulus test %0d", st_op[t], t);
          err_total++;
        end
      endcase
      if (err_total == err_before)
      begin
        n_pass++;
        $display("test %0d port %0d op %0d addr 0x%08h ok", t, st_port[t], st_op[t], st_addr[t]);
      end
      else
      begin
        n_fail++;
        $display("test %0d port %0d op %0d addr 0x%08h failed", t, st_port[t], st_op[t],
                 st_addr[t]);
      end
    end
    if (uart_expect.size() != 0)
    begin
      $display("%0d uart bytes were never sent", uart_expect.size());
      err_total++;
    end
    if (DUT.u_arbiter.u_chk.assert_fails != 0)
    begin
      $display("%0d arbiter protocol assertions failed", DUT.u_arbiter.u_chk.assert_fails);
      err_total++;
    end
    $display("tests %0d passed %0d failed %0d errors %0d", n_lines, n_pass, n_fail, err_total);
    if (n_fail == 0 && err_total == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verif/soc_bus_chk.sv ====
`timescale 1ns/1ns

module soc_bus_chk (
  input logic                   clk,
  input logic                   rst,
  input logic                   ifu_done_i,
  input logic                   lsu_done_i,
  input logic                   busy_i,
  input logic                   sram_req_i,
  input logic                   uart_req_i,
  input logic                   clint_req_i,
  input soc_bus_pkg::peer_sel_e sel_i
);

  int assert_fails = 0;

  // done is a single-cycle pulse on each requester
  a_ifu_done_pulse: assert property (@(posedge clk) disable iff (rst)
    ifu_done_i |=> !ifu_done_i)
  else
  begin
    $error("ifu done held for more than one cycle");
    assert_fails++;
  end

  a_lsu_done_pulse: assert property (@(posedge clk) disable iff (rst)
    lsu_done_i |=> !lsu_done_i)
  else
  begin
    $error("lsu done held for more than one cycle");
    assert_fails++;
  end

  a_done_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(ifu_done_i && lsu_done_i))
  else
  begin
    $error("ifu and lsu done in the same cycle");
    assert_fails++;
  end

  // a peer only sees req under a grant
  a_req_needs_grant: assert property (@(posedge clk) disable iff (rst)
    (sram_req_i || uart_req_i || clint_req_i) |-> busy_i)
  else
  begin
    $error("peer req raised without a grant");
    assert_fails++;
  end

  // sram and clint answer one cycle after the forwarded req
  a_peer_latency: assert property (@(posedge clk) disable iff (rst)
    ($rose(busy_i) &&
     (sel_i == soc_bus_pkg::SEL_SRAM || sel_i == soc_bus_pkg::SEL_CLINT))
    |=> (ifu_done_i || lsu_done_i))
  else
  begin
    $error("sram or clint did not answer one cycle after the grant");
    assert_fails++;
  end

endmodule

bind bus_arbiter soc_bus_chk u_chk (
  .clk         (clk),
  .rst         (rst),
  .ifu_done_i  (ifu_port.done),
  .lsu_done_i  (lsu_port.done),
  .busy_i      (busy),
  .sram_req_i  (sram_port.req),
  .uart_req_i  (uart_port.req),
  .clint_req_i (clint_port.req),
  .sel_i       (sel_q)
);

// ==== rtl/soc_bus_top.sv ====
`timescale 1ns/1ns

module soc_bus_top (
  input  logic                           clk,
  input  logic                           rst,
  // instruction fetch, read only
  input  logic                           ifu_req_i,
  input  logic [soc_bus_pkg::ADDR_W-1:0] ifu_addr_i,
  output logic [soc_bus_pkg::DATA_W-1:0] ifu_rdata_o,
  output logic                           ifu_done_o,
  // load/store
  input  logic                           lsu_req_i,
  input  logic                           lsu_we_i,
  input  logic [soc_bus_pkg::ADDR_W-1:0] lsu_addr_i,
  input  logic [soc_bus_pkg::DATA_W-1:0] lsu_wdata_i,
  input  logic [soc_bus_pkg::STRB_W-1:0] lsu_wstrb_i,
  output logic [soc_bus_pkg::DATA_W-1:0] lsu_rdata_o,
  output logic                           lsu_done_o,
  // uart byte stream
  input  logic                           uart_tx_ready_i,
  output logic [7:0]                     uart_tx_data_o,
  output logic                           uart_tx_valid_o
);

  bus_port_if ifu_port ();
  bus_port_if lsu_port ();
  bus_port_if sram_port ();
  bus_port_if uart_port ();
  bus_port_if clint_port ();

  // fetch never writes
  assign ifu_port.req   = ifu_req_i;
  assign ifu_port.we    = 1'b0;
  assign ifu_port.addr  = ifu_addr_i;
  assign ifu_port.wdata = '0;
  assign ifu_port.wstrb = '0;
  assign ifu_rdata_o    = ifu_port.rdata;
  assign ifu_done_o     = ifu_port.done;

  assign lsu_port.req   = lsu_req_i;
  assign lsu_port.we    = lsu_we_i;
  assign lsu_port.addr  = lsu_addr_i;
  assign lsu_port.wdata = lsu_wdata_i;
  assign lsu_port.wstrb = lsu_wstrb_i;
  assign lsu_rdata_o    = lsu_port.rdata;
  assign lsu_done_o     = lsu_port.done;

  bus_arbiter u_arbiter (
    .clk        (clk),
    .rst        (rst),
    .ifu_port   (ifu_port),
    .lsu_port   (lsu_port),
    .sram_port  (sram_port),
    .uart_port  (uart_port),
    .clint_port (clint_port)
  );

  scratch_sram u_sram (
    .clk  (clk),
    .port (sram_port)
  );

  uart_tx_port u_uart (
    .clk        (clk),
    .rst        (rst),
    .port       (uart_port),
    .tx_ready_i (uart_tx_ready_i),
    .tx_data_o  (uart_tx_data_o),
    .tx_valid_o (uart_tx_valid_o)
  );

  clint_timer u_clint (
    .clk  (clk),
    .rst  (rst),
    .port (clint_port)
  );

endmodule

// ==== rtl/clint_timer.sv ====
`timescale 1ns/1ns

module clint_timer (
  input logic           clk,
  input logic           rst,
  bus_port_if.responder port
);

  logic [63:0] mtime;
  logic serve;

  assign serve = port.req && !port.done;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime     <= '0;
      port.done <= 1'b0;
    end
    else
    begin
      mtime     <= mtime + 64'd1;
      port.done <= serve;
    end
  end

  // addr bit 2 picks the high word, writes just complete
  always_ff @(posedge clk)
  begin
    if (serve)
    begin
      if (port.we)
        port.rdata <= '0;
      else
        port.rdata <= port.addr[2] ? mtime[63:32] : mtime[31:0];
    end
  end

endmodule

// ==== rtl/uart_tx_port.sv ====
`timescale 1ns/1ns

module uart_tx_port (
  input  logic          clk,
  input  logic          rst,
  bus_port_if.responder port,
  input  logic          tx_ready_i,
  output logic [7:0]    tx_data_o,
  output logic          tx_valid_o
);

  logic [7:0] fifo_mem [soc_bus_pkg::UART_FIFO_DEPTH];
  logic [soc_bus_pkg::UART_PTR_W-1:0] wr_ptr;
  logic [soc_bus_pkg::UART_PTR_W-1:0] rd_ptr;
  logic [soc_bus_pkg::UART_CNT_W-1:0] count;
  logic full;
  logic accept;
  logic push;
  logic pop;

  assign full = (count == soc_bus_pkg::UART_FIFO_DEPTH);

  // a write waits here while the fifo is full
  assign accept = port.req && !port.done && (!port.we || !full);
  assign push   = accept && port.we;
  assign pop    = tx_valid_o && tx_ready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      port.done <= 1'b0;
    end
    else
    begin
      port.done <= accept;
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      fifo_mem[wr_ptr] <= port.wdata[7:0];
    // reads see the fill level
    if (accept)
      port.rdata <= {{(soc_bus_pkg::DATA_W-soc_bus_pkg::UART_CNT_W){1'b0}}, count};
  end

  assign tx_valid_o = (count != '0);
  assign tx_data_o  = fifo_mem[rd_ptr];

endmodule

// ==== rtl/scratch_sram.sv ====
`timescale 1ns/1ns

module scratch_sram (
  input logic           clk,
  bus_port_if.responder port
);

  logic [soc_bus_pkg::DATA_W-1:0] mem [soc_bus_pkg::SRAM_WORDS];
  logic [soc_bus_pkg::SRAM_IDX_W-1:0] idx;
  logic serve;

  // word index, wraps modulo the depth
  assign idx = port.addr[soc_bus_pkg::SRAM_IDX_W+soc_bus_pkg::BYTE_OFF_W-1:
                         soc_bus_pkg::BYTE_OFF_W];

  // done high means this req was already served
  assign serve = port.req && !port.done;

  always_ff @(posedge clk)
  begin
    port.done <= serve;
    if (serve)
    begin
      port.rdata <= mem[idx];
      if (port.we)
      begin
        for (int b = 0; b < soc_bus_pkg::STRB_W; b++)
        begin
          if (port.wstrb[b])
            mem[idx][8*b +: 8] <= port.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter (
  input logic           clk,
  input logic           rst,
  bus_port_if.responder ifu_port,
  bus_port_if.responder lsu_port,
  bus_port_if.requester sram_port,
  bus_port_if.requester uart_port,
  bus_port_if.requester clint_port
);

  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_IFU,
    GNT_LSU
  } gnt_e;

  gnt_e                   gnt_q;
  soc_bus_pkg::peer_sel_e sel_q;
  logic                   busy;
  logic                   peer_done;
  logic [soc_bus_pkg::DATA_W-1:0] peer_rdata;
  logic                   cur_we;
  logic [soc_bus_pkg::ADDR_W-1:0] cur_addr;
  logic [soc_bus_pkg::DATA_W-1:0] cur_wdata;
  logic [soc_bus_pkg::STRB_W-1:0] cur_wstrb;

  function automatic soc_bus_pkg::peer_sel_e decode(
    input logic [soc_bus_pkg::ADDR_W-1:0] a
  );
    soc_bus_pkg::peer_sel_e sel;
    if (a >= soc_bus_pkg::SRAM_BASE && (a - soc_bus_pkg::SRAM_BASE) < soc_bus_pkg::SRAM_SPAN)
      sel = soc_bus_pkg::SEL_SRAM;
    else if (a == soc_bus_pkg::UART_TX_ADDR)
      sel = soc_bus_pkg::SEL_UART;
    else if (a == soc_bus_pkg::MTIME_LO_ADDR || a == soc_bus_pkg::MTIME_HI_ADDR)
      sel = soc_bus_pkg::SEL_CLINT;
    else
      sel = soc_bus_pkg::SEL_NONE;
    return sel;
  endfunction

  // grant latch, lsu wins ties; back to idle after the done cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      gnt_q <= GNT_NONE;
      sel_q <= soc_bus_pkg::SEL_NONE;
    end
    else if (gnt_q == GNT_NONE)
    begin
      if (lsu_port.req)
      begin
        gnt_q <= GNT_LSU;
        sel_q <= decode(lsu_port.addr);
      end
      else if (ifu_port.req)
      begin
        gnt_q <= GNT_IFU;
        sel_q <= decode(ifu_port.addr);
      end
    end
    else if (peer_done)
      gnt_q <= GNT_NONE;
  end

  assign busy = (gnt_q != GNT_NONE);

  // granted requester holds its fields stable
  assign cur_we    = (gnt_q == GNT_LSU) ? lsu_port.we    : ifu_port.we;
  assign cur_addr  = (gnt_q == GNT_LSU) ? lsu_port.addr  : ifu_port.addr;
  assign cur_wdata = (gnt_q == GNT_LSU) ? lsu_port.wdata : ifu_port.wdata;
  assign cur_wstrb = (gnt_q == GNT_LSU) ? lsu_port.wstrb : ifu_port.wstrb;

  assign sram_port.req   = busy && (sel_q == soc_bus_pkg::SEL_SRAM);
  assign sram_port.we    = cur_we;
  assign sram_port.addr  = cur_addr;
  assign sram_port.wdata = cur_wdata;
  assign sram_port.wstrb = cur_wstrb;

  assign uart_port.req   = busy && (sel_q == soc_bus_pkg::SEL_UART);
  assign uart_port.we    = cur_we;
  assign uart_port.addr  = cur_addr;
  assign uart_port.wdata = cur_wdata;
  assign uart_port.wstrb = cur_wstrb;

  assign clint_port.req   = busy && (sel_q == soc_bus_pkg::SEL_CLINT);
  assign clint_port.we    = cur_we;
  assign clint_port.addr  = cur_addr;
  assign clint_port.wdata = cur_wdata;
  assign clint_port.wstrb = cur_wstrb;

  // unmapped target ends on its own with zero data
  always_comb
  begin
    case (sel_q)
      soc_bus_pkg::SEL_SRAM:
      begin
        peer_done  = sram_port.done;
        peer_rdata = sram_port.rdata;
      end
      soc_bus_pkg::SEL_UART:
      begin
        peer_done  = uart_port.done;
        peer_rdata = uart_port.rdata;
      end
      soc_bus_pkg::SEL_CLINT:
      begin
        peer_done  = clint_port.done;
        peer_rdata = clint_port.rdata;
      end
      default:
      begin
        peer_done  = 1'b1;
        peer_rdata = '0;
      end
    endcase
  end

  assign ifu_port.done  = (gnt_q == GNT_IFU) && peer_done;
  assign ifu_port.rdata = peer_rdata;
  assign lsu_port.done  = (gnt_q == GNT_LSU) && peer_done;
  assign lsu_port.rdata = peer_rdata;

endmodule

// ==== rtl/bus_port_if.sv ====
`timescale 1ns/1ns

interface bus_port_if;

  logic req;
  logic we;
  logic [soc_bus_pkg::ADDR_W-1:0] addr;
  logic [soc_bus_pkg::DATA_W-1:0] wdata;
  logic [soc_bus_pkg::STRB_W-1:0] wstrb;
  logic [soc_bus_pkg::DATA_W-1:0] rdata;
  // one-cycle completion pulse
  logic done;

  // requester holds everything until it sees done
  modport requester (
    output req, we, addr, wdata, wstrb,
    input  rdata, done
  );

  modport responder (
    input  req, we, addr, wdata, wstrb,
    output rdata, done
  );

endinterface

// ==== rtl/soc_bus_pkg.sv ====
package soc_bus_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int BYTE_OFF_W = $clog2(STRB_W);

  // scratch sram window
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
  localparam int SRAM_WORDS = 1024;
  localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);
  localparam logic [ADDR_W-1:0] SRAM_SPAN = ADDR_W'(SRAM_WORDS * STRB_W);

  // uart transmit data register
  localparam logic [ADDR_W-1:0] UART_TX_ADDR = 32'hA000_03F8;

  // clint mtime words, bit 2 picks the half
  localparam logic [ADDR_W-1:0] MTIME_LO_ADDR = 32'hA000_0048;
  localparam logic [ADDR_W-1:0] MTIME_HI_ADDR = 32'hA000_004C;

  // uart byte fifo
  localparam int UART_FIFO_DEPTH = 4;
  localparam int UART_PTR_W = $clog2(UART_FIFO_DEPTH);
  localparam int UART_CNT_W = $clog2(UART_FIFO_DEPTH + 1);

  // decode target
  typedef enum logic [1:0] {
    SEL_SRAM,
    SEL_UART,
    SEL_CLINT,
    SEL_NONE
  } peer_sel_e;

endpackage
